/* logic/wb_cfg.svh */
// Writeback subsystem configuration
// Sizes shared by the package and the RTL modules

`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// Reorder buffer entries, power of two
`define WB_ROB_DEPTH 8

// Datapath width in bits
`define WB_XLEN 32

// Architectural registers
`define WB_NREGS 16

// Multiplier pipeline depth in cycles, at least 2
`define WB_MUL_LAT 3

`endif

/* logic/wb_pkg.sv */
// Writeback subsystem types
// Operation codes, index types and the commit payload

`include "wb_cfg.svh"

package wb_pkg;

  //----------------------------------------
  // Operations
  //----------------------------------------

  // ADD, SUB and XOR go to the ALU, MUL to the multiplier
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } op_e;

  //----------------------------------------
  // Indices
  //----------------------------------------

  // Reorder slot, allocated in program order
  typedef logic [$clog2(`WB_ROB_DEPTH)-1:0] rob_idx_t;

  // Architectural register number
  typedef logic [$clog2(`WB_NREGS)-1:0] reg_idx_t;

  //----------------------------------------
  // Commit payload
  //----------------------------------------

  // Destination and result, 4 + 32 bits
  typedef struct packed {
    reg_idx_t             rd;
    logic [`WB_XLEN-1:0]  value;
  } commit_msg_t;

endpackage

/* logic/wb_issue_ctrl.sv */
// Issue controller
// Hands out reorder indices in order, counts live entries and steers
// each accepted operation to the ALU or the multiplier

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_issue_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_val,
  input  wb_pkg::op_e       issue_op,
  input  logic              commit_val,
  output logic              issue_rdy,
  output logic              alu_start,
  output logic              mul_start,
  output wb_pkg::rob_idx_t  alloc_idx
);

  localparam int CNT_W = $clog2(`WB_ROB_DEPTH + 1);

  //----------------------------------------
  // State
  //----------------------------------------

  logic             run_q;
  wb_pkg::rob_idx_t alloc_ptr;
  logic [CNT_W-1:0] occ_cnt;
  // Bit k set when a multiply was accepted k cycles ago
  logic [`WB_MUL_LAT-1:1] mul_sr;

  logic fire;
  logic is_mul;
  logic full;
  logic slot_taken;

  //----------------------------------------
  // Acceptance
  //----------------------------------------

  assign is_mul = (issue_op == wb_pkg::OP_MUL);
  assign full   = (occ_cnt == CNT_W'(`WB_ROB_DEPTH));

  // ALU result lands next cycle, same cycle as a multiply from LAT-1 ago
  assign slot_taken = mul_sr[`WB_MUL_LAT-1];

  // Held low for the first cycle after reset
  assign issue_rdy = run_q & ~full & (is_mul | ~slot_taken);
  assign fire      = issue_val & issue_rdy;

  // One strobe at most per cycle
  assign alu_start = fire & ~is_mul;
  assign mul_start = fire & is_mul;
  assign alloc_idx = alloc_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  //----------------------------------------
  // Index allocation
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_ptr <= '0;
    end else if (fire) begin
      // Wrap at the last entry
      if (alloc_ptr == wb_pkg::rob_idx_t'(`WB_ROB_DEPTH - 1)) begin
        alloc_ptr <= '0;
      end else begin
        alloc_ptr <= alloc_ptr + 1'b1;
      end
    end
  end

  // Occupancy, up on issue and down on commit
  always_ff @(posedge clk) begin
    if (rst) begin
      occ_cnt <= '0;
    end else begin
      case ({fire, commit_val})
        2'b10:   occ_cnt <= occ_cnt + 1'b1;
        2'b01:   occ_cnt <= occ_cnt - 1'b1;
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

  //----------------------------------------
  // Multiply completion tracking
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      mul_sr <= '0;
    end else begin
      mul_sr[1] <= mul_start;
      for (int i = 2; i < `WB_MUL_LAT; i++) begin
        mul_sr[i] <= mul_sr[i-1];
      end
    end
  end

endmodule

/* logic/wb_alu.sv */
// Single-cycle ALU
// Add, subtract or xor with the result and its index registered

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_alu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  wb_pkg::op_e          op,
  input  logic [`WB_XLEN-1:0]  a,
  input  logic [`WB_XLEN-1:0]  b,
  input  wb_pkg::reg_idx_t     rd,
  input  wb_pkg::rob_idx_t     idx,
  output logic                 done,
  output wb_pkg::rob_idx_t     done_idx,
  output wb_pkg::commit_msg_t  done_msg
);

  logic [`WB_XLEN-1:0] res;

  // Result select
  always_comb begin
    case (op)
      wb_pkg::OP_ADD: res = a + b;
      wb_pkg::OP_SUB: res = a - b;
      wb_pkg::OP_XOR: res = a ^ b;
      // Multiplies never steered here
      default:        res = '0;
    endcase
  end

  // Strobe, one cycle behind start
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // Payload, captured only on start
  always_ff @(posedge clk) begin
    if (start) begin
      done_idx       <= idx;
      done_msg.rd    <= rd;
      done_msg.value <= res;
    end
  end

endmodule

/* logic/wb_mul.sv */
// Pipelined multiplier
// Operand stage, product stage, then pass stages, MUL_LAT in all.
// Each stage carries a valid bit, so one multiply may enter per cycle

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_mul (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic [`WB_XLEN-1:0]  a,
  input  logic [`WB_XLEN-1:0]  b,
  input  wb_pkg::reg_idx_t     rd,
  input  wb_pkg::rob_idx_t     idx,
  output logic                 done,
  output wb_pkg::rob_idx_t     done_idx,
  output wb_pkg::commit_msg_t  done_msg
);

  localparam int LAT = `WB_MUL_LAT;

  //----------------------------------------
  // Stage registers
  //----------------------------------------

  logic [LAT-1:0]      st_val;
  wb_pkg::rob_idx_t    st_idx [LAT];
  wb_pkg::reg_idx_t    st_rd  [LAT];
  // Stage 0 holds operands
  logic [`WB_XLEN-1:0] op_a;
  logic [`WB_XLEN-1:0] op_b;
  // Stages 1 and up hold the product
  logic [`WB_XLEN-1:0] st_prod [1:LAT-1];

  // Valid chain
  always_ff @(posedge clk) begin
    if (rst) begin
      st_val <= '0;
    end else begin
      st_val <= {st_val[LAT-2:0], start};
    end
  end

  always_ff @(posedge clk) begin
    op_a      <= a;
    op_b      <= b;
    st_idx[0] <= idx;
    st_rd[0]  <= rd;
    // Low XLEN bits only, sized by the target
    st_prod[1] <= op_a * op_b;
    for (int i = 1; i < LAT; i++) begin
      st_idx[i] <= st_idx[i-1];
      st_rd[i]  <= st_rd[i-1];
    end
    for (int i = 2; i < LAT; i++) begin
      st_prod[i] <= st_prod[i-1];
    end
  end

  //----------------------------------------
  // Output
  //----------------------------------------

  assign done           = st_val[LAT-1];
  assign done_idx       = st_idx[LAT-1];
  assign done_msg.rd    = st_rd[LAT-1];
  assign done_msg.value = st_prod[LAT-1];

endmodule

/* logic/wb_rob.sv */
// Reorder buffer
// Results are inserted at their own index and retired in index order
// from a wrapping pointer. An insert at the retire slot can pass
// straight through in the same cycle

`timescale 1ns/1ns

module wb_rob #(
  parameter int  p_depth = 8,
  parameter type t_msg   = logic [31:0],
  localparam int p_idx_bits = $clog2(p_depth)
) (
  input  logic                  clk,
  input  logic                  rst,

  // Insert side
  input  logic [p_idx_bits-1:0] ins_idx,
  input  t_msg                  ins_msg,
  input  logic                  ins_en,

  // Retire side
  input  logic                  deq_en,
  output logic [p_idx_bits-1:0] deq_idx,
  output t_msg                  deq_msg,
  output logic                  deq_rdy
);

  //----------------------------------------
  // Storage
  //----------------------------------------

  logic [p_depth-1:0] ent_val;
  t_msg               ent_msg [p_depth];

  logic [p_idx_bits-1:0] deq_ptr;
  logic [p_idx_bits-1:0] deq_ptr_nxt;
  logic                  hit;
  logic                  bypass;
  logic                  deq_fire;
  logic                  ins_store;

  //----------------------------------------
  // Bypass and retire control
  //----------------------------------------

  // Incoming result is the oldest one
  assign hit       = ins_en & (ins_idx == deq_ptr);
  assign bypass    = hit & deq_en;
  assign deq_rdy   = ent_val[deq_ptr] | hit;
  assign deq_fire  = deq_en & deq_rdy;
  // Bypassed results never touch storage
  assign ins_store = ins_en & ~bypass;

  //----------------------------------------
  // Valid bits
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= '0;
    end else begin
      if (ins_store) begin
        ent_val[ins_idx] <= 1'b1;
      end
      // Never the same entry as ins_store
      if (deq_fire) begin
        ent_val[deq_ptr] <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (ins_store) begin
      ent_msg[ins_idx] <= ins_msg;
    end
  end

  //----------------------------------------
  // Retire pointer
  //----------------------------------------

  always_comb begin
    if (deq_ptr == p_idx_bits'(p_depth - 1)) begin
      deq_ptr_nxt = '0;
    end else begin
      deq_ptr_nxt = deq_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      deq_ptr <= '0;
    end else if (deq_fire) begin
      deq_ptr <= deq_ptr_nxt;
    end
  end

  //----------------------------------------
  // Outputs
  //----------------------------------------

  // Pointer equals ins_idx on a hit
  assign deq_idx = deq_ptr;
  assign deq_msg = hit ? ins_msg : ent_msg[deq_ptr];

endmodule

/* logic/wb_regfile.sv */
// Architectural register file
// One write port fed by commits, one asynchronous read port

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en,
  input  wb_pkg::reg_idx_t     wr_addr,
  input  logic [`WB_XLEN-1:0]  wr_data,
  input  wb_pkg::reg_idx_t     rd_addr,
  output logic [`WB_XLEN-1:0]  rd_data
);

  logic [`WB_XLEN-1:0] regs [`WB_NREGS];

  // All registers start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `WB_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Observation port, no read latency
  assign rd_data = regs[rd_addr];

endmodule

/* logic/wb_top.sv */
// Writeback subsystem top
// Issue controller, ALU, multiplier, reorder buffer and register file.
// Results from both units merge into the buffer insert port

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_val,
  input  wb_pkg::op_e          issue_op,
  input  wb_pkg::reg_idx_t     issue_rd,
  input  logic [`WB_XLEN-1:0]  issue_a,
  input  logic [`WB_XLEN-1:0]  issue_b,
  input  logic                 commit_en,
  input  wb_pkg::reg_idx_t     rd_addr,
  output logic                 issue_rdy,
  output logic                 commit_val,
  output wb_pkg::rob_idx_t     commit_idx,
  output wb_pkg::reg_idx_t     commit_rd,
  output logic [`WB_XLEN-1:0]  commit_value,
  output logic [`WB_XLEN-1:0]  rd_data
);

  //----------------------------------------
  // Internal nets
  //----------------------------------------

  logic                alu_start;
  logic                mul_start;
  wb_pkg::rob_idx_t    alloc_idx;

  logic                alu_done;
  wb_pkg::rob_idx_t    alu_idx;
  wb_pkg::commit_msg_t alu_msg;
  logic                mul_done;
  wb_pkg::rob_idx_t    mul_idx;
  wb_pkg::commit_msg_t mul_msg;

  logic                ins_en;
  wb_pkg::rob_idx_t    ins_idx;
  wb_pkg::commit_msg_t ins_msg;
  logic                deq_rdy;
  wb_pkg::commit_msg_t deq_msg;

  //----------------------------------------
  // Issue and execute
  //----------------------------------------

  wb_issue_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .issue_val  (issue_val),
    .issue_op   (issue_op),
    .commit_val (commit_val),
    .issue_rdy  (issue_rdy),
    .alu_start  (alu_start),
    .mul_start  (mul_start),
    .alloc_idx  (alloc_idx)
  );

  wb_alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .start    (alu_start),
    .op       (issue_op),
    .a        (issue_a),
    .b        (issue_b),
    .rd       (issue_rd),
    .idx      (alloc_idx),
    .done     (alu_done),
    .done_idx (alu_idx),
    .done_msg (alu_msg)
  );

  wb_mul u_mul (
    .clk      (clk),
    .rst      (rst),
    .start    (mul_start),
    .a        (issue_a),
    .b        (issue_b),
    .rd       (issue_rd),
    .idx      (alloc_idx),
    .done     (mul_done),
    .done_idx (mul_idx),
    .done_msg (mul_msg)
  );

  // Insert source, done strobes are exclusive
  assign ins_en  = alu_done | mul_done;
  assign ins_idx = alu_done ? alu_idx : mul_idx;
  assign ins_msg = alu_done ? alu_msg : mul_msg;

  //----------------------------------------
  // Reorder and commit
  //----------------------------------------

  wb_rob #(
    .p_depth (`WB_ROB_DEPTH),
    .t_msg   (wb_pkg::commit_msg_t)
  ) u_rob (
    .clk     (clk),
    .rst     (rst),
    .ins_idx (ins_idx),
    .ins_msg (ins_msg),
    .ins_en  (ins_en),
    .deq_en  (commit_en),
    .deq_idx (commit_idx),
    .deq_msg (deq_msg),
    .deq_rdy (deq_rdy)
  );

  assign commit_val   = deq_rdy & commit_en;
  assign commit_rd    = deq_msg.rd;
  assign commit_value = deq_msg.value;

  wb_regfile u_rf (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (commit_val),
    .wr_addr (commit_rd),
    .wr_data (commit_value),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* verif/wb_assert.sv */
// Writeback subsystem checker
// Bound to wb_top. Covers reset quiet time, commit order,
// occupancy limits and the bypass path

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_assert (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_val,
  input  logic              issue_rdy,
  input  wb_pkg::op_e       issue_op,
  input  logic              commit_en,
  input  logic              commit_val,
  input  wb_pkg::rob_idx_t  commit_idx,
  input  logic              alu_done,
  input  logic              mul_done
);

  // Failed assertion count for the testbench
  int err_cnt = 0;

  wb_pkg::rob_idx_t exp_idx;
  int               occ;

  //----------------------------------------
  // Reference state
  //----------------------------------------

  // Next index to retire and live entry count
  always_ff @(posedge clk) begin
    if (rst) begin
      exp_idx <= '0;
      occ     <= 0;
    end else begin
      if (commit_val) begin
        exp_idx <= exp_idx + 1'b1;
      end
      occ <= occ + int'(issue_val && issue_rdy) - int'(commit_val);
    end
  end

  //----------------------------------------
  // Properties
  //----------------------------------------

  // Quiet after each reset edge and in the first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk) rst |=> !issue_rdy && !commit_val)
    else begin $error("issue_rdy or commit_val high during or right after reset"); err_cnt++; end

  // Strict index order wrapping at the depth
  a_commit_order: assert property (@(posedge clk) disable iff (rst)
    commit_val |-> commit_idx == exp_idx)
    else begin $error("commit index out of order"); err_cnt++; end

  a_occ_bound: assert property (@(posedge clk) disable iff (rst) occ <= `WB_ROB_DEPTH)
    else begin $error("more live entries than the buffer holds"); err_cnt++; end

  // Full buffer stalls issue
  a_full_stall: assert property (@(posedge clk) disable iff (rst)
    occ == `WB_ROB_DEPTH |-> !issue_rdy)
    else begin $error("issue accepted with the buffer full"); err_cnt++; end

  a_done_excl: assert property (@(posedge clk) disable iff (rst) !(alu_done && mul_done))
    else begin $error("both unit results in one cycle"); err_cnt++; end

  // Lone ALU op into an empty buffer commits next cycle
  a_bypass: assert property (@(posedge clk) disable iff (rst)
    (issue_val && issue_rdy && issue_op != wb_pkg::OP_MUL && occ == 0) ##1 commit_en
    |-> commit_val)
    else begin $error("ALU result missed the bypass path"); err_cnt++; end

endmodule

/* verif/wb_tb.sv */
// Writeback subsystem testbench
// LFSR driven issue and commit traffic, checked against an in-order model

`timescale 1ns/1ns

`include "wb_cfg.svh"

module wb_tb;

  localparam int          WAIT_MAX = 200;
  localparam logic [15:0] SEED     = 16'd33256;

  logic                clk;
  logic                rst;
  logic                issue_val;
  wb_pkg::op_e         issue_op;
  wb_pkg::reg_idx_t    issue_rd;
  logic [`WB_XLEN-1:0] issue_a;
  logic [`WB_XLEN-1:0] issue_b;
  logic                commit_en;
  wb_pkg::reg_idx_t    rd_addr;
  logic                issue_rdy;
  logic                commit_val;
  wb_pkg::rob_idx_t    commit_idx;
  wb_pkg::reg_idx_t    commit_rd;
  logic [`WB_XLEN-1:0] commit_value;
  logic [`WB_XLEN-1:0] rd_data;

  // Expected commits in program order
  wb_pkg::commit_msg_t exp_q [$];
  // Last committed value per register
  logic [`WB_XLEN-1:0] shadow [`WB_NREGS];

  logic [15:0] stim_lfsr;
  logic [15:0] cen_lfsr;
  // 0 holds commit_en low, 1 holds it high, else random
  int          cen_mode;
  int          err_cnt;
  int          timeout_cnt;
  int          commit_cnt;

  wb_top UUT (
    .clk          (clk),
    .rst          (rst),
    .issue_val    (issue_val),
    .issue_op     (issue_op),
    .issue_rd     (issue_rd),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .commit_en    (commit_en),
    .rd_addr      (rd_addr),
    .issue_rdy    (issue_rdy),
    .commit_val   (commit_val),
    .commit_idx   (commit_idx),
    .commit_rd    (commit_rd),
    .commit_value (commit_value),
    .rd_data      (rd_data)
  );

  bind wb_top wb_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .issue_val  (issue_val),
    .issue_rdy  (issue_rdy),
    .issue_op   (issue_op),
    .commit_en  (commit_en),
    .commit_val (commit_val),
    .commit_idx (commit_idx),
    .alu_done   (alu_done),
    .mul_done   (mul_done)
  );

  always #5 clk = ~clk;

  //----------------------------------------
  // Random source and operation rules
  //----------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic stim_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  function automatic logic [`WB_XLEN-1:0] expected_value(input wb_pkg::op_e op,
      input logic [`WB_XLEN-1:0] a, input logic [`WB_XLEN-1:0] b);
    case (op)
      wb_pkg::OP_ADD: return a + b;
      wb_pkg::OP_SUB: return a - b;
      wb_pkg::OP_XOR: return a ^ b;
      // Low half of the product
      default:        return a * b;
    endcase
  endfunction

  //----------------------------------------
  // Commit enable pattern
  //----------------------------------------

  always @(posedge clk) begin
    int   mode;
    logic b0;
    // Mode sampled at the edge and driven just after it
    mode = cen_mode;
    #1;
    case (mode)
      0: commit_en = 1'b0;
      1: commit_en = 1'b1;
      default: begin
        cen_lfsr = lfsr_next(cen_lfsr);
        b0 = cen_lfsr[0];
        cen_lfsr = lfsr_next(cen_lfsr);
        // High about three cycles in four
        commit_en = b0 | cen_lfsr[0];
      end
    endcase
  end

  //----------------------------------------
  // Reference model
  //----------------------------------------

  always @(negedge clk) begin
    wb_pkg::commit_msg_t exp;
    if (!rst) begin
      // Accepted at the coming edge
      if (issue_val && issue_rdy) begin
        exp.rd    = issue_rd;
        exp.value = expected_value(issue_op, issue_a, issue_b);
        exp_q.push_back(exp);
      end
      if (commit_val) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: commit with no outstanding operation");
          err_cnt++;
        end else begin
          exp = exp_q.pop_front();
          assert (commit_rd == exp.rd) else begin
            $display("FAILED: commit_rd got %h expected %h", commit_rd, exp.rd);
            err_cnt++;
          end
          assert (commit_value == exp.value) else begin
            $display("FAILED: commit_value got %h expected %h", commit_value, exp.value);
            err_cnt++;
          end
          shadow[exp.rd] = exp.value;
          commit_cnt++;
        end
      end
    end
  end

  //----------------------------------------
  // Stimulus tasks
  //----------------------------------------

  // Holds the op at the port until accepted
  task automatic send_op(input wb_pkg::op_e op, input wb_pkg::reg_idx_t rd,
      input logic [`WB_XLEN-1:0] a, input logic [`WB_XLEN-1:0] b, output int waited);
    issue_val = 1'b1;
    issue_op  = op;
    issue_rd  = rd;
    issue_a   = a;
    issue_b   = b;
    waited    = 0;
    @(negedge clk);
    while (!issue_rdy && waited < WAIT_MAX) begin
      waited++;
      @(negedge clk);
    end
    if (!issue_rdy) begin
      $display("ERROR: operation not accepted within %0d cycles", WAIT_MAX);
      timeout_cnt++;
    end
    @(posedge clk);
    #1;
    issue_val = 1'b0;
  endtask

  task automatic random_op();
    logic [31:0] v_op;
    logic [31:0] v_rd;
    logic [31:0] v_a;
    logic [31:0] v_b;
    int          waited;
    stim_bits(2, v_op);
    stim_bits(4, v_rd);
    stim_bits(32, v_a);
    stim_bits(32, v_b);
    send_op(wb_pkg::op_e'(v_op[1:0]), wb_pkg::reg_idx_t'(v_rd), v_a, v_b, waited);
  endtask

  task automatic drain_pipeline();
    int waited;
    cen_mode = 1;
    waited   = 0;
    while (exp_q.size() != 0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d results still pending after %0d cycles", exp_q.size(), WAIT_MAX);
      timeout_cnt++;
    end
    // Back to the drive point just after the rising edge
    @(posedge clk);
    #1;
  endtask

  // ALU result into an empty buffer commits through the bypass
  task automatic bypass_check();
    int waited;
    cen_mode = 1;
    @(posedge clk);
    #1;
    send_op(wb_pkg::OP_ADD, wb_pkg::reg_idx_t'(3), 32'h1234_0000, 32'h0000_5678, waited);
    @(negedge clk);
    assert (commit_val) else begin
      $display("FAILED: commit_val got %h expected %h", commit_val, 1'b1);
      err_cnt++;
    end
    drain_pipeline();
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] gap;
    cen_mode = 2;
    for (int i = 0; i < n; i++) begin
      random_op();
      if (timeout_cnt != 0) begin
        return;
      end
      // Idle cycle now and then
      stim_bits(1, gap);
      if (gap[0]) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Multiplies interleaved with ALU ops finish out of order
  task automatic mul_burst();
    wb_pkg::op_e seq [8];
    logic [31:0] v_rd;
    logic [31:0] v_a;
    logic [31:0] v_b;
    int          waited;
    seq = '{wb_pkg::OP_MUL, wb_pkg::OP_ADD, wb_pkg::OP_MUL, wb_pkg::OP_XOR,
            wb_pkg::OP_MUL, wb_pkg::OP_MUL, wb_pkg::OP_SUB, wb_pkg::OP_ADD};
    cen_mode = 1;
    for (int i = 0; i < 8; i++) begin
      stim_bits(4, v_rd);
      stim_bits(32, v_a);
      stim_bits(32, v_b);
      send_op(seq[i], wb_pkg::reg_idx_t'(v_rd), v_a, v_b, waited);
      if (timeout_cnt != 0) begin
        return;
      end
    end
    drain_pipeline();
  endtask

  // Commit held off until the buffer is full, then released
  task automatic fill_and_release();
    logic [31:0] v_rd;
    logic [31:0] v_a;
    logic [31:0] v_b;
    int          waited;
    int          accepted;
    cen_mode = 0;
    @(posedge clk);
    #1;
    accepted = 0;
    for (int i = 0; i < `WB_ROB_DEPTH; i++) begin
      stim_bits(4, v_rd);
      stim_bits(32, v_a);
      stim_bits(32, v_b);
      send_op(wb_pkg::op_e'(i % 3), wb_pkg::reg_idx_t'(v_rd), v_a, v_b, waited);
      if (timeout_cnt != 0) begin
        return;
      end
      if (waited == 0) begin
        accepted++;
      end
    end
    assert (accepted == `WB_ROB_DEPTH) else begin
      $display("ERROR: only %0d of %0d issues accepted at once", accepted, `WB_ROB_DEPTH);
      err_cnt++;
    end
    // One more op waits at the port
    issue_val = 1'b1;
    issue_op  = wb_pkg::OP_SUB;
    issue_rd  = wb_pkg::reg_idx_t'(9);
    issue_a   = 32'h0000_0100;
    issue_b   = 32'h0000_0200;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      assert (!issue_rdy) else begin
        $display("FAILED: issue_rdy got %h expected %h", issue_rdy, 1'b0);
        err_cnt++;
      end
      assert (!commit_val) else begin
        $display("FAILED: commit_val got %h expected %h", commit_val, 1'b0);
        err_cnt++;
      end
    end
    cen_mode = 1;
    send_op(issue_op, issue_rd, issue_a, issue_b, waited);
    if (timeout_cnt == 0) begin
      drain_pipeline();
    end
  endtask

  task automatic register_readback();
    for (int r = 0; r < `WB_NREGS; r++) begin
      @(posedge clk);
      #1;
      rd_addr = wb_pkg::reg_idx_t'(r);
      @(negedge clk);
      assert (rd_data == shadow[r]) else begin
        $display("FAILED: rd_data reg %0d got %h expected %h", r, rd_data, shadow[r]);
        err_cnt++;
      end
    end
  endtask

  //----------------------------------------
  // Sequence
  //----------------------------------------

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    issue_val   = 1'b0;
    issue_op    = wb_pkg::OP_ADD;
    issue_rd    = '0;
    issue_a     = '0;
    issue_b     = '0;
    commit_en   = 1'b0;
    rd_addr     = '0;
    stim_lfsr   = SEED;
    cen_lfsr    = SEED;
    cen_mode    = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    commit_cnt  = 0;
    for (int r = 0; r < `WB_NREGS; r++) begin
      shadow[r] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    bypass_check();
    if (timeout_cnt == 0) begin
      random_traffic(60);
    end
    if (timeout_cnt == 0) begin
      mul_burst();
    end
    if (timeout_cnt == 0) begin
      drain_pipeline();
    end
    if (timeout_cnt == 0) begin
      fill_and_release();
    end
    if (timeout_cnt == 0) begin
      random_traffic(40);
    end
    if (timeout_cnt == 0) begin
      drain_pipeline();
    end
    if (timeout_cnt == 0) begin
      register_readback();
    end
    $display("commits %0d, check errors %0d, assertion errors %0d, timeouts %0d",
             commit_cnt, err_cnt, UUT.u_assert.err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && UUT.u_assert.err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* wb.f */
+incdir+logic
logic/wb_pkg.sv
logic/wb_issue_ctrl.sv
logic/wb_alu.sv
logic/wb_mul.sv
logic/wb_rob.sv
logic/wb_regfile.sv
logic/wb_top.sv
verif/wb_assert.sv
verif/wb_tb.sv

/* Bender.yml */
package:
  name: wb

sources:
  - include_dirs:
      - logic
    files:
      - logic/wb_pkg.sv
      - logic/wb_issue_ctrl.sv
      - logic/wb_alu.sv
      - logic/wb_mul.sv
      - logic/wb_rob.sv
      - logic/wb_regfile.sv
      - logic/wb_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/wb_assert.sv
      - verif/wb_tb.sv
